//--- src/vram_pkg.sv
`default_nettype none

package vram_pkg;

    // vram geometry
    localparam int ADDR_W     = 12;
    localparam int VRAM_WORDS = 2 ** ADDR_W;

    typedef logic [15:0]       word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    // bit n enables nibble n, bit 0 is the low nibble
    typedef logic [3:0]        mask_t;

    // one vram access as issued by a master
    typedef struct packed {
        logic  wr;
        mask_t wr_mask;
        addr_t addr;
        word_t data;
    } vram_req_t;

    // scanline fetch
    localparam int LINE_WORDS = 16;
    localparam int FETCH_SLOT = 4;
    localparam int SLOT_W     = $clog2(FETCH_SLOT);
    localparam int LINE_CNT_W = $clog2(LINE_WORDS + 1);

    // host bus
    localparam int AXI_AW = 16;
    localparam int AXI_DW = 32;

endpackage

`default_nettype wire

//--- src/vram.sv
`default_nettype none
`timescale 1ns/1ps

module vram (
    input  wire logic            clk,
    input  wire logic            sel_i,
    input  wire logic            wr_i,
    input  wire vram_pkg::mask_t wr_mask_i,
    input  wire vram_pkg::addr_t addr_i,
    input  wire vram_pkg::word_t data_i,
    output vram_pkg::word_t      data_o
);
    import vram_pkg::*;

    word_t mem [VRAM_WORDS];

    // masked write, only enabled nibbles change
    always_ff @(posedge clk) begin
        if (sel_i && wr_i) begin
            for (int n = 0; n < 4; n++) begin
                if (wr_mask_i[n]) begin
                    mem[addr_i][4*n +: 4] <= data_i[4*n +: 4];
                end
            end
        end
    end

    // registered read on every access, holds otherwise
    // a write returns the word as it was before the update
    always_ff @(posedge clk) begin
        if (sel_i) begin
            data_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- src/vram_arb.sv
`default_nettype none
`timescale 1ns/1ps

module vram_arb (
    input  wire logic                clk,
    input  wire logic                reset_i,

    // scanline fetch, read only
    input  wire logic                vgen_sel_i,
    input  wire vram_pkg::addr_t     vgen_addr_i,

    // host register port, read and write
    input  wire logic                regs_sel_i,
    input  wire vram_pkg::vram_req_t regs_req_i,
    output logic                     regs_ack_o,

    // shared read data
    output vram_pkg::word_t          vram_data_o
);
    import vram_pkg::*;

    logic      vram_sel;
    logic      regs_grant;
    vram_req_t vram_req;

    // fixed priority, video first
    always_comb begin
        regs_grant = 1'b0;
        vram_sel   = 1'b0;
        // write fields follow the register port unless video takes the slot
        vram_req   = regs_req_i;
        if (vgen_sel_i) begin
            vram_sel      = 1'b1;
            vram_req.wr   = 1'b0;
            vram_req.addr = vgen_addr_i;
        end else if (regs_sel_i && !regs_ack_o) begin
            // no second grant while the previous one is being acked
            regs_grant = 1'b1;
            vram_sel   = 1'b1;
        end
    end

    // ack lines up with the registered read data
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_ack_o <= 1'b0;
        end else begin
            regs_ack_o <= regs_grant;
        end
    end

    vram u_vram (
        .clk       (clk),
        .sel_i     (vram_sel),
        .wr_i      (vram_req.wr),
        .wr_mask_i (vram_req.wr_mask),
        .addr_i    (vram_req.addr),
        .data_i    (vram_req.data),
        .data_o    (vram_data_o)
    );

endmodule

`default_nettype wire

//--- src/video_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module video_fetch (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            fetch_start_i,
    input  wire vram_pkg::addr_t fetch_base_i,
    output logic                 vgen_sel_o,
    output vram_pkg::addr_t      vgen_addr_o,
    input  wire vram_pkg::word_t vram_data_i,
    output logic                 fetch_busy_o,
    output vram_pkg::word_t      pix_word_o,
    output logic                 pix_valid_o
);
    import vram_pkg::*;

    logic [SLOT_W-1:0]     slot_cnt;
    logic [LINE_CNT_W-1:0] word_cnt;
    logic                  sel_q;
    logic                  line_done;

    assign line_done = (word_cnt == LINE_CNT_W'(LINE_WORDS));

    // first read goes out in the first busy cycle
    assign vgen_sel_o = fetch_busy_o && (slot_cnt == '0) && !line_done;

    // vram read is registered, so data is back one cycle after the select
    assign pix_valid_o = sel_q;
    assign pix_word_o  = vram_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_busy_o <= 1'b0;
            slot_cnt     <= '0;
            word_cnt     <= '0;
            vgen_addr_o  <= '0;
            sel_q        <= 1'b0;
        end else begin
            sel_q <= vgen_sel_o;
            if (!fetch_busy_o) begin
                // starts are only taken when idle
                if (fetch_start_i) begin
                    fetch_busy_o <= 1'b1;
                    slot_cnt     <= '0;
                    word_cnt     <= '0;
                    vgen_addr_o  <= fetch_base_i;
                end
            end else begin
                if (slot_cnt == SLOT_W'(FETCH_SLOT - 1)) begin
                    slot_cnt <= '0;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
                if (vgen_sel_o) begin
                    word_cnt    <= word_cnt + 1'b1;
                    vgen_addr_o <= vgen_addr_o + 1'b1;
                end
                // done once the last word has been handed out
                if (sel_q && line_done) begin
                    fetch_busy_o <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/axil_vram_regs.sv
`default_nettype none
`timescale 1ns/1ps

module axil_vram_regs (
    input  wire logic                         clk,
    input  wire logic                         reset_i,

    // write address
    input  wire logic [vram_pkg::AXI_AW-1:0]  s_awaddr_i,
    input  wire logic                         s_awvalid_i,
    output logic                              s_awready_o,

    // write data
    input  wire logic [vram_pkg::AXI_DW-1:0]  s_wdata_i,
    input  wire logic [3:0]                   s_wstrb_i,
    input  wire logic                         s_wvalid_i,
    output logic                              s_wready_o,

    // write response
    output logic [1:0]                        s_bresp_o,
    output logic                              s_bvalid_o,
    input  wire logic                         s_bready_i,

    // read address
    input  wire logic [vram_pkg::AXI_AW-1:0]  s_araddr_i,
    input  wire logic                         s_arvalid_i,
    output logic                              s_arready_o,

    // read data
    output logic [vram_pkg::AXI_DW-1:0]       s_rdata_o,
    output logic [1:0]                        s_rresp_o,
    output logic                              s_rvalid_o,
    input  wire logic                         s_rready_i,

    // arbiter side
    output logic                              regs_sel_o,
    output vram_pkg::vram_req_t               regs_req_o,
    input  wire logic                         regs_ack_i,
    input  wire vram_pkg::word_t              vram_data_i
);
    import vram_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WRESP,
        ST_RRESP
    } state_t;

    state_t            state;
    logic              wr_accept;
    logic              rd_accept;
    vram_req_t         req_q;
    logic [AXI_DW-1:0] rdata_q;

    // write needs aw and w together, and wins over a pending read
    assign wr_accept = (state == ST_IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_accept = (state == ST_IDLE) && s_arvalid_i && !(s_awvalid_i && s_wvalid_i);

    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;
    assign s_arready_o = rd_accept;

    // always OKAY
    assign s_bresp_o  = 2'b00;
    assign s_bvalid_o = (state == ST_WRESP);
    assign s_rresp_o  = 2'b00;
    assign s_rvalid_o = (state == ST_RRESP);
    assign s_rdata_o  = rdata_q;

    // select drops in the ack cycle
    assign regs_sel_o = (state == ST_ACCESS) && !regs_ack_i;
    assign regs_req_o = req_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    // request held until the arbiter acks it
                    if (regs_ack_i) begin
                        state <= req_q.wr ? ST_WRESP : ST_RRESP;
                    end
                end
                ST_WRESP: begin
                    if (s_bready_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (s_rready_i) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // byte address to word address, low two strobes to nibble pairs
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            req_q.wr      <= 1'b1;
            req_q.wr_mask <= {{2{s_wstrb_i[1]}}, {2{s_wstrb_i[0]}}};
            req_q.addr    <= s_awaddr_i[ADDR_W+1:2];
            req_q.data    <= s_wdata_i[$bits(word_t)-1:0];
        end else if (rd_accept) begin
            req_q.wr      <= 1'b0;
            req_q.wr_mask <= '0;
            req_q.addr    <= s_araddr_i[ADDR_W+1:2];
        end
        // read data is valid on the ack cycle
        if ((state == ST_ACCESS) && regs_ack_i && !req_q.wr) begin
            rdata_q <= AXI_DW'(vram_data_i);
        end
    end

endmodule

`default_nettype wire

//--- src/vram_subsys_top.sv
`default_nettype none
`timescale 1ns/1ps

module vram_subsys_top (
    input  wire logic                         clk,
    input  wire logic                         reset_i,

    // host bus
    input  wire logic [vram_pkg::AXI_AW-1:0]  s_awaddr_i,
    input  wire logic                         s_awvalid_i,
    output logic                              s_awready_o,
    input  wire logic [vram_pkg::AXI_DW-1:0]  s_wdata_i,
    input  wire logic [3:0]                   s_wstrb_i,
    input  wire logic                         s_wvalid_i,
    output logic                              s_wready_o,
    output logic [1:0]                        s_bresp_o,
    output logic                              s_bvalid_o,
    input  wire logic                         s_bready_i,
    input  wire logic [vram_pkg::AXI_AW-1:0]  s_araddr_i,
    input  wire logic                         s_arvalid_i,
    output logic                              s_arready_o,
    output logic [vram_pkg::AXI_DW-1:0]       s_rdata_o,
    output logic [1:0]                        s_rresp_o,
    output logic                              s_rvalid_o,
    input  wire logic                         s_rready_i,

    // scanline fetch
    input  wire logic                         fetch_start_i,
    input  wire vram_pkg::addr_t              fetch_base_i,
    output logic                              fetch_busy_o,
    output vram_pkg::word_t                   pix_word_o,
    output logic                              pix_valid_o
);
    import vram_pkg::*;

    logic      vgen_sel;
    addr_t     vgen_addr;
    logic      regs_sel;
    vram_req_t regs_req;
    logic      regs_ack;
    word_t     vram_data;

    vram_arb u_vram_arb (
        .clk         (clk),
        .reset_i     (reset_i),
        .vgen_sel_i  (vgen_sel),
        .vgen_addr_i (vgen_addr),
        .regs_sel_i  (regs_sel),
        .regs_req_i  (regs_req),
        .regs_ack_o  (regs_ack),
        .vram_data_o (vram_data)
    );

    video_fetch u_video_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_start_i (fetch_start_i),
        .fetch_base_i  (fetch_base_i),
        .vgen_sel_o    (vgen_sel),
        .vgen_addr_o   (vgen_addr),
        .vram_data_i   (vram_data),
        .fetch_busy_o  (fetch_busy_o),
        .pix_word_o    (pix_word_o),
        .pix_valid_o   (pix_valid_o)
    );

    axil_vram_regs u_axil_vram_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .regs_sel_o  (regs_sel),
        .regs_req_o  (regs_req),
        .regs_ack_i  (regs_ack),
        .vram_data_i (vram_data)
    );

endmodule

`default_nettype wire

//--- verification/vram_arb_checker.sv
`default_nettype none
`timescale 1ns/1ps

module vram_arb_checker (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic vgen_sel_i,
    input wire logic regs_ack_i,
    input wire logic pix_valid_i
);

    // ack is a single-cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (reset_i)
        regs_ack_i |=> !regs_ack_i)
        else $error("regs_ack high for two cycles in a row");

    // a video slot means the register port was not granted
    a_ack_after_vgen: assert property (@(posedge clk) disable iff (reset_i)
        vgen_sel_i |=> !regs_ack_i)
        else $error("regs_ack follows a cycle with vgen_sel high");

    a_pix_after_sel: assert property (@(posedge clk) disable iff (reset_i)
        vgen_sel_i |=> pix_valid_i)
        else $error("pix_valid missing one cycle after vgen_sel");

    a_pix_source: assert property (@(posedge clk) disable iff (reset_i)
        pix_valid_i |-> $past(vgen_sel_i))
        else $error("pix_valid without vgen_sel in the cycle before");

endmodule

// arbiter signals are wired in the top level
bind vram_subsys_top vram_arb_checker u_arb_chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .vgen_sel_i  (vgen_sel),
    .regs_ack_i  (regs_ack),
    .pix_valid_i (pix_valid_o)
);

`default_nettype wire

//--- verification/vram_scoreboard.sv
`default_nettype none
`timescale 1ns/1ps

module vram_scoreboard (
    input wire logic                        clk,
    input wire logic                        reset_i,
    input wire logic [vram_pkg::AXI_AW-1:0] awaddr_i,
    input wire logic                        awvalid_i,
    input wire logic                        awready_i,
    input wire logic [vram_pkg::AXI_DW-1:0] wdata_i,
    input wire logic [3:0]                  wstrb_i,
    input wire logic                        wvalid_i,
    input wire logic                        wready_i,
    input wire logic [1:0]                  bresp_i,
    input wire logic                        bvalid_i,
    input wire logic                        bready_i,
    input wire logic [vram_pkg::AXI_AW-1:0] araddr_i,
    input wire logic                        arvalid_i,
    input wire logic                        arready_i,
    input wire logic [vram_pkg::AXI_DW-1:0] rdata_i,
    input wire logic [1:0]                  rresp_i,
    input wire logic                        rvalid_i,
    input wire logic                        rready_i,
    input wire logic                        fetch_start_i,
    input wire vram_pkg::addr_t             fetch_base_i,
    input wire logic                        fetch_busy_i,
    input wire vram_pkg::word_t             pix_word_i,
    input wire logic                        pix_valid_i
);
    import vram_pkg::*;

    // model words, plus which bits of each word are known
    word_t       model [VRAM_WORDS];
    word_t       known [VRAM_WORDS];
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          cyc = 0;
    int          acc_cyc = 0;
    logic        rst_q = 1'b1;
    logic        bvalid_q = 1'b0;
    logic        bready_q = 1'b0;
    logic        rvalid_q = 1'b0;
    logic        rready_q = 1'b0;
    logic [31:0] rdata_q = '0;
    addr_t       rd_addr = '0;
    addr_t       wa;
    addr_t       pa;
    logic        f_active = 1'b0;
    addr_t       f_base = '0;
    int          f_idx = 0;
    int          f_next = 0;

    initial begin
        for (int i = 0; i < VRAM_WORDS; i++) begin
            known[i] = '0;
            model[i] = '0;
        end
    end

    task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("[FAIL] t=%0t %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (reset_i) begin
            rst_q    = 1'b1;
            f_active = 1'b0;
        end else begin
            if (rst_q) begin
                check("bvalid after reset", 32'(bvalid_i), 0);
                check("rvalid after reset", 32'(rvalid_i), 0);
                check("fetch_busy after reset", 32'(fetch_busy_i), 0);
                check("pix_valid after reset", 32'(pix_valid_i), 0);
                rst_q = 1'b0;
            end
            if (awready_i && !(awvalid_i && wvalid_i)) begin
                report_error("awready raised without both awvalid and wvalid");
            end
            if (wready_i && !(awvalid_i && wvalid_i)) begin
                report_error("wready raised without both awvalid and wvalid");
            end
            if (arready_i && !arvalid_i) begin
                report_error("arready raised without arvalid");
            end
            if ((awready_i || wready_i || arready_i) && (bvalid_i || rvalid_i)) begin
                report_error("new address accepted while a response is pending");
            end
            // held responses must not move
            if (bvalid_q && !bready_q) begin
                check("bvalid held", 32'(bvalid_i), 1);
            end
            if (rvalid_q && !rready_q) begin
                check("rvalid held", 32'(rvalid_i), 1);
                check("rdata held", rdata_i, rdata_q);
            end
            if (bvalid_i) begin
                check("bresp", 32'(bresp_i), 0);
            end
            if (rvalid_i) begin
                check("rresp", 32'(rresp_i), 0);
            end

            // wstrb 0 covers the low byte, wstrb 1 the high byte
            if (awvalid_i && awready_i && wvalid_i && wready_i) begin
                wa = awaddr_i[ADDR_W+1:2];
                if (wstrb_i[0]) begin
                    model[wa][7:0] = wdata_i[7:0];
                    known[wa][7:0] = 8'hff;
                end
                if (wstrb_i[1]) begin
                    model[wa][15:8] = wdata_i[15:8];
                    known[wa][15:8] = 8'hff;
                end
                acc_cyc = cyc;
            end
            if (arvalid_i && arready_i) begin
                rd_addr = araddr_i[ADDR_W+1:2];
                acc_cyc = cyc;
            end
            if (bvalid_i && !bvalid_q && (cyc - acc_cyc < 2)) begin
                report_error("write response came less than two cycles after acceptance");
            end
            if (rvalid_i && !rvalid_q) begin
                if (cyc - acc_cyc < 2) begin
                    report_error("read data came less than two cycles after acceptance");
                end
                check("rdata", rdata_i & {16'hffff, known[rd_addr]},
                      {16'h0000, model[rd_addr] & known[rd_addr]});
            end

            // line fetch stream
            if (pix_valid_i) begin
                if (!f_active || f_idx >= LINE_WORDS) begin
                    report_error("pix_valid outside of an expected line fetch");
                end else begin
                    check("pix_valid cycle", cyc, f_next);
                    check("fetch_busy during line", 32'(fetch_busy_i), 1);
                    pa = addr_t'(f_base + f_idx);
                    check("pix_word", 32'(pix_word_i & known[pa]),
                          32'(model[pa] & known[pa]));
                    f_idx++;
                    f_next = cyc + FETCH_SLOT;
                end
            end else if (f_active && f_idx < LINE_WORDS && cyc > f_next) begin
                report_error("pix_valid missing in a line fetch");
                f_active = 1'b0;
            end
            if (f_active && f_idx == LINE_WORDS && cyc == f_next - FETCH_SLOT + 1) begin
                check("fetch_busy after last word", 32'(fetch_busy_i), 0);
                f_active = 1'b0;
            end
            // a start is only taken while idle
            if (fetch_start_i && !fetch_busy_i) begin
                f_active = 1'b1;
                f_base   = fetch_base_i;
                f_idx    = 0;
                f_next   = cyc + 2;
            end
        end
        bvalid_q = bvalid_i;
        bready_q = bready_i;
        rvalid_q = rvalid_i;
        rready_q = rready_i;
        rdata_q  = rdata_i;
        cyc++;
    end

endmodule

`default_nettype wire

//--- verification/vram_tb.sv
`default_nettype none
`timescale 1ns/1ps

module vram_tb;
    import vram_pkg::*;

    localparam logic [31:0] SEED = 32'h9c53b7a6;
    localparam int N_RW    = 24;
    localparam int N_MASK  = 8;
    localparam int N_CONT  = 12;
    localparam int N_BP    = 2;
    localparam int N_FETCH = 2;
    localparam int N_TRANS = 2 * N_RW + 2 * N_MASK + LINE_WORDS + N_CONT + N_BP;
    // a few extra cycles cover reset and the idle test
    localparam int WATCHDOG_CYC = N_TRANS * 20 + N_FETCH * (LINE_WORDS * FETCH_SLOT + 10) + 10;
    localparam addr_t LINE_BASE = 12'h100;

    logic              clk;
    logic              reset_i;
    logic [AXI_AW-1:0] s_awaddr;
    logic              s_awvalid;
    logic              s_awready;
    logic [AXI_DW-1:0] s_wdata;
    logic [3:0]        s_wstrb;
    logic              s_wvalid;
    logic              s_wready;
    logic [1:0]        s_bresp;
    logic              s_bvalid;
    logic              s_bready;
    logic [AXI_AW-1:0] s_araddr;
    logic              s_arvalid;
    logic              s_arready;
    logic [AXI_DW-1:0] s_rdata;
    logic [1:0]        s_rresp;
    logic              s_rvalid;
    logic              s_rready;
    logic              fetch_start;
    addr_t             fetch_base;
    logic              fetch_busy;
    word_t             pix_word;
    logic              pix_valid;

    // handshakes seen at the rising edge, read back on the falling edge
    logic aw_hs = 1'b0;
    logic ar_hs = 1'b0;
    logic b_hs  = 1'b0;
    logic r_hs  = 1'b0;

    addr_t wr_addrs [N_RW];
    int    err_mark = 0;

    vram_subsys_top u_dut (
        .clk (clk), .reset_i (reset_i),
        .s_awaddr_i (s_awaddr), .s_awvalid_i (s_awvalid), .s_awready_o (s_awready),
        .s_wdata_i (s_wdata), .s_wstrb_i (s_wstrb), .s_wvalid_i (s_wvalid),
        .s_wready_o (s_wready),
        .s_bresp_o (s_bresp), .s_bvalid_o (s_bvalid), .s_bready_i (s_bready),
        .s_araddr_i (s_araddr), .s_arvalid_i (s_arvalid), .s_arready_o (s_arready),
        .s_rdata_o (s_rdata), .s_rresp_o (s_rresp), .s_rvalid_o (s_rvalid),
        .s_rready_i (s_rready),
        .fetch_start_i (fetch_start), .fetch_base_i (fetch_base),
        .fetch_busy_o (fetch_busy), .pix_word_o (pix_word), .pix_valid_o (pix_valid)
    );

    vram_scoreboard u_sb (
        .clk (clk), .reset_i (reset_i),
        .awaddr_i (s_awaddr), .awvalid_i (s_awvalid), .awready_i (s_awready),
        .wdata_i (s_wdata), .wstrb_i (s_wstrb), .wvalid_i (s_wvalid), .wready_i (s_wready),
        .bresp_i (s_bresp), .bvalid_i (s_bvalid), .bready_i (s_bready),
        .araddr_i (s_araddr), .arvalid_i (s_arvalid), .arready_i (s_arready),
        .rdata_i (s_rdata), .rresp_i (s_rresp), .rvalid_i (s_rvalid), .rready_i (s_rready),
        .fetch_start_i (fetch_start), .fetch_base_i (fetch_base),
        .fetch_busy_i (fetch_busy), .pix_word_i (pix_word), .pix_valid_i (pix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        aw_hs <= s_awvalid && s_awready;
        ar_hs <= s_arvalid && s_arready;
        b_hs  <= s_bvalid && s_bready;
        r_hs  <= s_rvalid && s_rready;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYC);
        $display("Finished with errors");
        $finish;
    end

    // hold > 0 keeps bready low that many cycles and offers a read meanwhile
    task automatic axi_write(input addr_t a, input logic [31:0] d, input logic [3:0] strb,
                             input int hold);
        @(negedge clk);
        s_awaddr  = AXI_AW'({a, 2'b00});
        s_wdata   = d;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = (hold == 0);
        do @(negedge clk); while (!aw_hs);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (hold > 0) begin
            while (!s_bvalid) @(negedge clk);
            s_araddr  = AXI_AW'({a, 2'b00});
            s_arvalid = 1'b1;
            repeat (hold) @(negedge clk);
            s_arvalid = 1'b0;
            s_bready  = 1'b1;
        end
        do @(negedge clk); while (!b_hs);
    endtask

    // hold > 0 keeps rready low and offers a write meanwhile
    task automatic axi_read(input addr_t a, input int hold);
        @(negedge clk);
        s_araddr  = AXI_AW'({a, 2'b00});
        s_arvalid = 1'b1;
        s_rready  = (hold == 0);
        do @(negedge clk); while (!ar_hs);
        s_arvalid = 1'b0;
        if (hold > 0) begin
            while (!s_rvalid) @(negedge clk);
            s_awaddr  = AXI_AW'({a, 2'b00});
            s_wstrb   = 4'hf;
            s_awvalid = 1'b1;
            s_wvalid  = 1'b1;
            repeat (hold) @(negedge clk);
            s_awvalid = 1'b0;
            s_wvalid  = 1'b0;
            s_rready  = 1'b1;
        end
        do @(negedge clk); while (!r_hs);
    endtask

    // retrig > 0 pulses a second start that many cycles into the line
    task automatic fetch_line(input addr_t base, input int retrig);
        @(negedge clk);
        fetch_start = 1'b1;
        fetch_base  = base;
        @(negedge clk);
        fetch_start = 1'b0;
        if (retrig > 0) begin
            repeat (retrig) @(negedge clk);
            fetch_start = 1'b1;
            fetch_base  = base + 12'h040;
            @(negedge clk);
            fetch_start = 1'b0;
        end
        while (fetch_busy) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %-12s : %s", name, (u_sb.err_cnt == err_mark) ? "ok" : "failed");
        err_mark = u_sb.err_cnt;
    endtask

    initial begin
        void'($urandom(SEED));
        reset_i     = 1'b1;
        s_awaddr    = '0;
        s_awvalid   = 1'b0;
        s_wdata     = '0;
        s_wstrb     = '0;
        s_wvalid    = 1'b0;
        s_bready    = 1'b1;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b1;
        fetch_start = 1'b0;
        fetch_base  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        repeat (3) @(negedge clk);
        report_test("reset");

        for (int i = 0; i < N_RW; i++) begin
            wr_addrs[i] = addr_t'($urandom);
            axi_write(wr_addrs[i], $urandom, 4'hf, 0);
        end
        for (int i = 0; i < N_RW; i++) begin
            axi_read(wr_addrs[i], 0);
        end
        report_test("write_read");

        for (int i = 0; i < N_MASK; i++) begin
            axi_write(wr_addrs[i], $urandom, (i % 2 == 0) ? 4'h1 : 4'h2, 0);
        end
        for (int i = 0; i < N_MASK; i++) begin
            axi_read(wr_addrs[i], 0);
        end
        report_test("nibble_mask");

        for (int i = 0; i < LINE_WORDS; i++) begin
            axi_write(LINE_BASE + addr_t'(i), $urandom, 4'hf, 0);
        end
        fetch_line(LINE_BASE, 0);
        report_test("line_fetch");

        // host writes stay out of the line so the stream is fixed
        fork
            fetch_line(LINE_BASE, 9);
            for (int i = 0; i < N_CONT; i++) begin
                if ($urandom % 2 == 0) begin
                    axi_write(12'h800 | addr_t'($urandom % 12'h800), $urandom, 4'hf, 0);
                end else begin
                    axi_read(wr_addrs[$urandom % N_RW], 0);
                end
            end
        join
        report_test("contention");

        axi_write(wr_addrs[0], $urandom, 4'hf, 5);
        axi_read(wr_addrs[0], 5);
        report_test("backpressure");

        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", u_sb.chk_cnt, u_sb.err_cnt);
        if (u_sb.err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/vram_pkg.sv
src/vram.sv
src/vram_arb.sv
src/video_fetch.sv
src/axil_vram_regs.sv
src/vram_subsys_top.sv
verification/vram_arb_checker.sv
verification/vram_scoreboard.sv
verification/vram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vram subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module vram_tb -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vvram_tb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1
